//--- design/hand_bus_config.svh
`ifndef HAND_BUS_CONFIG_SVH
`define HAND_BUS_CONFIG_SVH

// frame headers, sent high byte first
`define HB_REQUEST_HEADER 32'hABADBABE
`define HB_RESPONSE_HEADER 32'hB000B135
`define HB_COMMAND_HEADER 32'hB105F00D

`define HB_HEADER_LEN 4
`define HB_REQUEST_LEN 7
`define HB_COMMAND_LEN 15
`define HB_RESPONSE_LEN 32
`define HB_JOINTS 4

`define HB_CLKS_PER_BIT 8
`define HB_POLL_INTERVAL 8000     // cycles per round
`define HB_RESPONSE_TIMEOUT 4000
`define HB_CRC_INIT 16'hFFFF

`endif

//--- design/hand_bus_pkg.sv
`default_nettype none
`include "hand_bus_config.svh"

package hand_bus_pkg;

	typedef logic signed [15:0] joint_word_t;
	typedef joint_word_t [`HB_JOINTS-1:0] joint_array_t;   // joint 0 in low slot

	typedef enum logic [2:0] {
		LINK_NONE,
		LINK_OK,
		LINK_CRC_ERROR,
		LINK_ID_ERROR,
		LINK_TIMEOUT
	} link_status_t;

	typedef enum logic {FRAME_REQUEST, FRAME_COMMAND} frame_kind_t;

	// ccitt poly 0x1021, msb first
	function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		logic fb;
		int i;
		c = crc;
		for (i = 7; i >= 0; i--) begin
			fb = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (fb)
				c = c ^ 16'h1021;
		end
		return c;
	endfunction

endpackage

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "hand_bus_config.svh"

module uart_rx (
	input wire clk,
	input wire reset,
	input wire rx,
	output logic byte_valid,
	output logic [7:0] data
);
	localparam int CNT_W = $clog2(`HB_CLKS_PER_BIT);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic bit_end;

	assign bit_end = clk_cnt == CNT_W'(`HB_CLKS_PER_BIT - 1);
	assign data = shift;   // stable until next data bit

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			byte_valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == CNT_W'(`HB_CLKS_PER_BIT / 2 - 1)) begin   // mid start bit
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				default: begin
					if (bit_end) begin
						byte_valid <= rx_sync;   // low stop bit drops the byte
						state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_sync, shift[7:1]};   // lsb first
	end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "hand_bus_config.svh"

module uart_tx (
	input wire clk,
	input wire reset,
	input wire start,
	input wire [7:0] data,
	output logic tx,
	output logic busy,
	output logic done
);
	localparam int CNT_W = $clog2(`HB_CLKS_PER_BIT);

	logic [CNT_W-1:0] clk_cnt;
	logic [3:0] bit_idx;
	logic [9:0] frame;
	logic bit_end;

	assign bit_end = clk_cnt == CNT_W'(`HB_CLKS_PER_BIT - 1);
	assign tx = busy ? frame[0] : 1'b1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin   // end of stop bit
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start)
			frame <= {1'b1, data, 1'b0};
		else if (busy && bit_end)
			frame <= {1'b1, frame[9:1]};
	end

endmodule

`default_nettype wire

//--- design/status_frame_receiver.sv
`timescale 1ns/1ps
`default_nettype none
`include "hand_bus_config.svh"

module status_frame_receiver (
	input wire clk,
	input wire reset,
	input wire byte_valid,
	input wire [7:0] data,
	input wire listen,
	input wire [7:0] hand_id,
	input wire hand_bus_pkg::joint_array_t setpoint,
	output logic result_valid,
	output hand_bus_pkg::link_status_t result,
	output logic setpoint_mismatch,
	output hand_bus_pkg::joint_array_t position,
	output hand_bus_pkg::joint_array_t current
);
	localparam int BODY_BYTES = `HB_RESPONSE_LEN - `HB_HEADER_LEN;
	// top bit of each field inside the body shift register
	localparam int ECHO_TOP = 8 * (`HB_RESPONSE_LEN - 7) + 7;
	localparam int POS_TOP = 8 * (`HB_RESPONSE_LEN - 15) + 7;
	localparam int CUR_TOP = 8 * (`HB_RESPONSE_LEN - 23) + 7;

	logic [31:0] window;
	logic fresh;
	logic collecting;
	logic frame_end;
	logic header_match;
	logic [4:0] byte_idx;
	logic [15:0] crc;
	logic [8*BODY_BYTES-1:0] body;
	hand_bus_pkg::joint_array_t rx_echo;
	hand_bus_pkg::joint_array_t rx_position;
	hand_bus_pkg::joint_array_t rx_current;

	assign header_match = fresh && !collecting && window == `HB_RESPONSE_HEADER;

	always_comb begin
		int j;
		for (j = 0; j < `HB_JOINTS; j++) begin
			rx_echo[j] = body[ECHO_TOP - 16*j -: 16];
			rx_position[j] = body[POS_TOP - 16*j -: 16];
			rx_current[j] = body[CUR_TOP - 16*j -: 16];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			window <= '0;
			fresh <= 1'b0;
			collecting <= 1'b0;
			frame_end <= 1'b0;
			byte_idx <= '0;
			crc <= `HB_CRC_INIT;
			result_valid <= 1'b0;
			result <= hand_bus_pkg::LINK_NONE;
			setpoint_mismatch <= 1'b0;
			position <= '0;
			current <= '0;
		end else begin
			fresh <= byte_valid;
			frame_end <= 1'b0;
			result_valid <= 1'b0;
			if (byte_valid)
				window <= {window[23:0], data};
			if (!listen) begin
				collecting <= 1'b0;   // partial frame dropped
			end else if (header_match) begin
				collecting <= 1'b1;
				byte_idx <= 5'(`HB_HEADER_LEN);
				crc <= `HB_CRC_INIT;
			end else if (collecting && byte_valid) begin
				byte_idx <= byte_idx + 1'b1;
				if (byte_idx < 5'(`HB_RESPONSE_LEN - 2))
					crc <= hand_bus_pkg::crc16_step(crc, data);
				if (byte_idx == 5'(`HB_RESPONSE_LEN - 1)) begin
					collecting <= 1'b0;
					frame_end <= 1'b1;
				end
			end
			if (frame_end && listen) begin
				result_valid <= 1'b1;
				setpoint_mismatch <= rx_echo != setpoint;
				if (body[15:0] != crc) begin
					result <= hand_bus_pkg::LINK_CRC_ERROR;
				end else if (body[8*BODY_BYTES-1 -: 8] != hand_id) begin
					result <= hand_bus_pkg::LINK_ID_ERROR;
				end else begin
					result <= hand_bus_pkg::LINK_OK;
					position <= rx_position;
					current <= rx_current;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (collecting && byte_valid)
			body <= {body[8*BODY_BYTES-9:0], data};   // byte 4 ends up on top
	end

endmodule

`default_nettype wire

//--- design/poll_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "hand_bus_config.svh"

module poll_sequencer (
	input wire clk,
	input wire reset,
	input wire frame_done,
	input wire result_valid,
	input wire hand_bus_pkg::link_status_t result,
	input wire setpoint_mismatch,
	output logic send,
	output hand_bus_pkg::frame_kind_t frame_kind,
	output logic listen,
	output hand_bus_pkg::link_status_t link_status,
	output logic status_valid
);
	localparam int INTERVAL_W = $clog2(`HB_POLL_INTERVAL);
	localparam int TIMEOUT_W = $clog2(`HB_RESPONSE_TIMEOUT);

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_REQUEST, SEQ_LISTEN, SEQ_COMMAND} seq_state_t;

	seq_state_t state;
	logic [INTERVAL_W-1:0] interval_cnt;
	logic [TIMEOUT_W-1:0] wait_cnt;
	logic tick;
	logic round_pending;   // interval elapsed while busy

	assign tick = interval_cnt == INTERVAL_W'(`HB_POLL_INTERVAL - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= SEQ_IDLE;
			interval_cnt <= '0;
			wait_cnt <= '0;
			round_pending <= 1'b0;
			send <= 1'b0;
			frame_kind <= hand_bus_pkg::FRAME_REQUEST;
			listen <= 1'b0;
			link_status <= hand_bus_pkg::LINK_NONE;
			status_valid <= 1'b0;
		end else begin
			send <= 1'b0;
			status_valid <= 1'b0;
			interval_cnt <= tick ? '0 : interval_cnt + 1'b1;
			if (tick)
				round_pending <= 1'b1;
			case (state)
				SEQ_IDLE: begin
					if (tick || round_pending) begin
						round_pending <= 1'b0;
						send <= 1'b1;
						frame_kind <= hand_bus_pkg::FRAME_REQUEST;
						state <= SEQ_REQUEST;
					end
				end
				SEQ_REQUEST: begin
					if (frame_done) begin
						listen <= 1'b1;
						wait_cnt <= '0;
						state <= SEQ_LISTEN;
					end
				end
				SEQ_LISTEN: begin
					if (result_valid) begin
						listen <= 1'b0;
						status_valid <= 1'b1;
						link_status <= result;
						state <= SEQ_IDLE;
						if (result == hand_bus_pkg::LINK_OK && setpoint_mismatch) begin
							send <= 1'b1;   // hand needs new setpoints
							frame_kind <= hand_bus_pkg::FRAME_COMMAND;
							state <= SEQ_COMMAND;
						end
					end else if (wait_cnt == TIMEOUT_W'(`HB_RESPONSE_TIMEOUT - 1)) begin
						listen <= 1'b0;
						status_valid <= 1'b1;
						link_status <= hand_bus_pkg::LINK_TIMEOUT;
						state <= SEQ_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: begin
					if (frame_done)
						state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/frame_transmitter.sv
`timescale 1ns/1ps
`default_nettype none
`include "hand_bus_config.svh"

module frame_transmitter (
	input wire clk,
	input wire reset,
	input wire send,
	input wire hand_bus_pkg::frame_kind_t frame_kind,
	input wire [7:0] hand_id,
	input wire hand_bus_pkg::joint_array_t setpoint,
	output logic tx_start,
	output logic [7:0] tx_data,
	input wire tx_done,
	output logic tx_enable,
	output logic frame_done
);
	hand_bus_pkg::frame_kind_t kind_q;
	logic [7:0] id_q;
	hand_bus_pkg::joint_array_t setpoint_q;
	hand_bus_pkg::joint_word_t sp_word;
	logic [3:0] byte_idx;   // next byte to launch
	logic [3:0] frame_len;
	logic [3:0] sp_off;
	logic [15:0] crc;
	logic [31:0] header;
	logic first_q;
	logic active;

	assign frame_len = (kind_q == hand_bus_pkg::FRAME_REQUEST) ?
		4'(`HB_REQUEST_LEN) : 4'(`HB_COMMAND_LEN);
	assign header = (kind_q == hand_bus_pkg::FRAME_REQUEST) ?
		`HB_REQUEST_HEADER : `HB_COMMAND_HEADER;
	assign sp_off = byte_idx - 4'd5;
	assign sp_word = setpoint_q[sp_off[2:1]];
	assign tx_start = first_q || (tx_done && active && byte_idx != frame_len);
	assign frame_done = tx_done && active && byte_idx == frame_len;
	assign tx_enable = active;

	always_comb begin
		if (byte_idx < 4'd4)
			tx_data = header[31 - 8*byte_idx[1:0] -: 8];
		else if (byte_idx == 4'd4)
			tx_data = id_q;
		else if (byte_idx == frame_len - 4'd2)
			tx_data = crc[15:8];
		else if (byte_idx == frame_len - 4'd1)
			tx_data = crc[7:0];
		else
			tx_data = sp_off[0] ? sp_word[7:0] : sp_word[15:8];   // high byte first
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			kind_q <= hand_bus_pkg::FRAME_REQUEST;
			byte_idx <= '0;
			crc <= `HB_CRC_INIT;
			first_q <= 1'b0;
			active <= 1'b0;
		end else begin
			first_q <= 1'b0;
			if (send && !active) begin
				kind_q <= frame_kind;
				byte_idx <= '0;
				crc <= `HB_CRC_INIT;
				first_q <= 1'b1;
				active <= 1'b1;
			end else if (frame_done) begin
				active <= 1'b0;
			end
			if (tx_start) begin
				byte_idx <= byte_idx + 1'b1;
				// crc covers id up to the byte before the crc
				if (byte_idx >= 4'd4 && byte_idx < frame_len - 4'd2)
					crc <= hand_bus_pkg::crc16_step(crc, tx_data);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (send && !active) begin
			id_q <= hand_id;
			setpoint_q <= setpoint;
		end
	end

endmodule

`default_nettype wire

//--- design/hand_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module hand_bus_master (
	input wire clk,
	input wire reset,
	input wire rx,
	output wire tx,
	output wire tx_enable,
	input wire [7:0] hand_id,
	input wire hand_bus_pkg::joint_array_t setpoint,
	output wire hand_bus_pkg::joint_array_t position,
	output wire hand_bus_pkg::joint_array_t current,
	output hand_bus_pkg::link_status_t link_status,
	output wire status_valid
);
	logic rx_valid;
	logic [7:0] rx_data;
	logic result_valid;
	hand_bus_pkg::link_status_t result;
	logic setpoint_mismatch;
	logic send;
	hand_bus_pkg::frame_kind_t frame_kind;
	logic listen;
	logic frame_done;
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_done;

	// receive side
	uart_rx u_rx (.clk, .reset, .rx, .byte_valid(rx_valid), .data(rx_data));

	status_frame_receiver u_receiver (
		.clk, .reset, .byte_valid(rx_valid), .data(rx_data), .listen, .hand_id, .setpoint,
		.result_valid, .result, .setpoint_mismatch, .position, .current
	);

	poll_sequencer u_sequencer (
		.clk, .reset, .frame_done, .result_valid, .result, .setpoint_mismatch,
		.send, .frame_kind, .listen, .link_status, .status_valid
	);

	// transmit side
	frame_transmitter u_transmitter (
		.clk, .reset, .send, .frame_kind, .hand_id, .setpoint,
		.tx_start, .tx_data, .tx_done, .tx_enable, .frame_done
	);

	uart_tx u_tx (
		.clk, .reset, .start(tx_start), .data(tx_data), .tx, .busy(), .done(tx_done)
	);

endmodule

`default_nettype wire

//--- bench/hand_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "hand_bus_config.svh"

module hand_bus_checker (
	input wire clk,
	input wire reset,
	input wire tx,
	input wire tx_enable,
	input wire rx,
	input wire [7:0] hand_id,
	input wire hand_bus_pkg::joint_array_t setpoint,
	input wire hand_bus_pkg::joint_array_t position,
	input wire hand_bus_pkg::joint_array_t current,
	input wire hand_bus_pkg::link_status_t link_status,
	input wire status_valid,
	output int error_count,
	output int test_count,
	output int request_count
);
	int tx_errors;
	int tx_tests;
	int status_errors;
	int status_tests;
	int status_count;
	int commands_owed;   // rounds that ended with a setpoint mismatch
	int commands_seen;
	int response_round;  // request number the last response belongs to
	hand_bus_pkg::link_status_t exp_status;
	hand_bus_pkg::joint_array_t exp_position;
	hand_bus_pkg::joint_array_t exp_current;
	logic exp_mismatch;

	assign error_count = tx_errors + status_errors;
	assign test_count = tx_tests + status_tests;

	// x^16+x^12+x^5+1, msb first
	function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		int i;
		c = crc ^ {b, 8'h00};
		for (i = 0; i < 8; i++)
			c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
		return c;
	endfunction

	task automatic compare(inout int errs, input string test, input string field,
			input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			errs++;
			$display("FAIL %s %s: expected %h, actual %h", test, field, expected, actual);
		end
	endtask

	task automatic complain(inout int errs, input string test, input string what);
		errs++;
		$display("ERROR %s: %s", test, what);
	endtask

	task automatic finish_test(input string test, input int errs);
		if (errs == 0)
			$display("test %s: ok", test);
		else
			$display("test %s: %0d problems", test, errs);
	endtask

	// tx changes on posedge, so sample on negedge
	task automatic read_tx_byte(output logic [7:0] b, inout int enable_low);
		int i;
		@(negedge tx);
		repeat (`HB_CLKS_PER_BIT / 2) @(negedge clk);
		for (i = 0; i < 9; i++) begin
			if (!tx_enable)
				enable_low++;
			repeat (`HB_CLKS_PER_BIT) @(negedge clk);
			if (i < 8)
				b[i] = tx;
		end
		if (!tx_enable)
			enable_low++;
	endtask

	// rx is driven on negedge by the hand model
	task automatic read_rx_byte(output logic [7:0] b);
		int i;
		@(negedge rx);
		repeat (`HB_CLKS_PER_BIT / 2) @(posedge clk);
		for (i = 0; i < 8; i++) begin
			repeat (`HB_CLKS_PER_BIT) @(posedge clk);
			b[i] = rx;
		end
		repeat (`HB_CLKS_PER_BIT) @(posedge clk);
	endtask

	initial begin : tx_monitor
		logic [7:0] frame [0:`HB_COMMAND_LEN-1];
		logic [31:0] header;
		logic [15:0] crc;
		string name;
		int enable_low;
		int errs;
		int commands;
		int k;
		int j;
		tx_errors = 0;
		tx_tests = 0;
		request_count = 0;
		commands_seen = 0;
		commands = 0;
		@(negedge reset);
		forever begin
			enable_low = 0;
			errs = 0;
			for (k = 0; k < `HB_HEADER_LEN; k++)
				read_tx_byte(frame[k], enable_low);
			header = {frame[0], frame[1], frame[2], frame[3]};
			if (header == `HB_REQUEST_HEADER) begin
				for (k = `HB_HEADER_LEN; k < `HB_REQUEST_LEN; k++)
					read_tx_byte(frame[k], enable_low);
				request_count++;
				name = $sformatf("request %0d", request_count);
				compare(errs, name, "id", 64'(hand_id), 64'(frame[4]));
				crc = crc16_update(`HB_CRC_INIT, frame[4]);
				compare(errs, name, "crc", 64'(crc), 64'({frame[5], frame[6]}));
				if (request_count > status_count + 1)
					complain(errs, name, "previous request got no status_valid");
				if (commands_seen != commands_owed) begin
					complain(errs, name, "command frame missing after a setpoint mismatch");
					commands_seen = commands_owed;
				end
			end else if (header == `HB_COMMAND_HEADER) begin
				for (k = `HB_HEADER_LEN; k < `HB_COMMAND_LEN; k++)
					read_tx_byte(frame[k], enable_low);
				commands++;
				name = $sformatf("command %0d", commands);
				compare(errs, name, "id", 64'(hand_id), 64'(frame[4]));
				for (j = 0; j < `HB_JOINTS; j++)
					compare(errs, name, $sformatf("setpoint %0d", j),
						64'($unsigned(setpoint[j])), 64'({frame[5 + 2*j], frame[6 + 2*j]}));
				crc = `HB_CRC_INIT;
				for (k = `HB_HEADER_LEN; k < `HB_COMMAND_LEN - 2; k++)
					crc = crc16_update(crc, frame[k]);
				compare(errs, name, "crc", 64'(crc), 64'({frame[13], frame[14]}));
				if (commands_seen >= commands_owed)
					complain(errs, name, "command frame sent without a setpoint mismatch");
				else
					commands_seen++;
			end else begin
				name = "tx frame";
				complain(errs, name, $sformatf("unknown header %h on tx", header));
			end
			if (enable_low != 0)
				complain(errs, name, "tx_enable dropped during the frame");
			tx_errors += errs;
			tx_tests++;
			finish_test(name, errs);
		end
	end

	initial begin : rx_monitor
		logic [7:0] resp [0:`HB_RESPONSE_LEN-1];
		logic [15:0] crc;
		hand_bus_pkg::joint_array_t echo;
		int k;
		int j;
		response_round = 0;
		@(negedge reset);
		forever begin
			for (k = 0; k < `HB_RESPONSE_LEN; k++)
				read_rx_byte(resp[k]);
			crc = `HB_CRC_INIT;
			for (k = `HB_HEADER_LEN; k < `HB_RESPONSE_LEN - 2; k++)
				crc = crc16_update(crc, resp[k]);
			for (j = 0; j < `HB_JOINTS; j++) begin
				echo[j] = {resp[6 + 2*j], resp[7 + 2*j]};
				exp_position[j] = {resp[14 + 2*j], resp[15 + 2*j]};
				exp_current[j] = {resp[22 + 2*j], resp[23 + 2*j]};
			end
			if (crc != {resp[30], resp[31]})
				exp_status = hand_bus_pkg::LINK_CRC_ERROR;
			else if (resp[4] != hand_id)
				exp_status = hand_bus_pkg::LINK_ID_ERROR;
			else
				exp_status = hand_bus_pkg::LINK_OK;
			exp_mismatch = echo != setpoint;
			response_round = request_count;
		end
	end

	initial begin : status_monitor
		hand_bus_pkg::joint_array_t last_position;
		hand_bus_pkg::joint_array_t last_current;
		hand_bus_pkg::link_status_t expected;
		string name;
		int errs;
		status_errors = 0;
		status_tests = 0;
		status_count = 0;
		commands_owed = 0;
		last_position = '0;
		last_current = '0;
		@(negedge reset);
		@(negedge clk);
		errs = 0;
		compare(errs, "reset state", "tx", 64'(1'b1), 64'(tx));
		compare(errs, "reset state", "tx_enable", 64'(1'b0), 64'(tx_enable));
		compare(errs, "reset state", "status_valid", 64'(1'b0), 64'(status_valid));
		compare(errs, "reset state", "link_status", 64'(hand_bus_pkg::LINK_NONE),
			64'(link_status));
		status_errors += errs;
		status_tests++;
		finish_test("reset state", errs);
		forever begin
			@(negedge clk);
			if (status_valid) begin
				status_count++;
				errs = 0;
				name = $sformatf("status %0d", status_count);
				if (status_count > request_count)
					complain(errs, name, "status_valid without a request");
				// no response since the last request means a timeout
				expected = (response_round == request_count) ? exp_status :
					hand_bus_pkg::LINK_TIMEOUT;
				if (expected == hand_bus_pkg::LINK_OK) begin
					last_position = exp_position;
					last_current = exp_current;
					if (exp_mismatch)
						commands_owed++;
				end
				compare(errs, name, "link_status", 64'(expected), 64'(link_status));
				compare(errs, name, "position", last_position, position);
				compare(errs, name, "current", last_current, current);
				status_errors += errs;
				status_tests++;
				finish_test(name, errs);
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_hand_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "hand_bus_config.svh"

module tb_hand_bus;
	localparam int ROUNDS = 30;
	localparam int WATCHDOG_NS = 40 * `HB_POLL_INTERVAL * 100 * 2;

	logic clk;
	logic reset;
	logic rx;
	logic [7:0] hand_id;
	hand_bus_pkg::joint_array_t setpoint;
	wire tx;
	wire tx_enable;
	wire status_valid;
	hand_bus_pkg::joint_array_t position;
	hand_bus_pkg::joint_array_t current;
	hand_bus_pkg::link_status_t link_status;
	int error_count;
	int test_count;
	int request_count;
	integer seed;

	hand_bus_master dut (
		.clk, .reset, .rx, .tx, .tx_enable, .hand_id, .setpoint,
		.position, .current, .link_status, .status_valid
	);

	hand_bus_checker chk (
		.clk, .reset, .tx, .tx_enable, .rx, .hand_id, .setpoint, .position, .current,
		.link_status, .status_valid, .error_count, .test_count, .request_count
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [15:0] crc_next(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		int i;
		c = crc ^ {b, 8'h00};
		for (i = 0; i < 8; i++)
			c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
		return c;
	endfunction

	task automatic take_tx_byte(output logic [7:0] b);
		int i;
		@(negedge tx);
		repeat (`HB_CLKS_PER_BIT / 2) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			repeat (`HB_CLKS_PER_BIT) @(negedge clk);
			b[i] = tx;
		end
		repeat (`HB_CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic send_rx_byte(input logic [7:0] b);
		logic [9:0] bits;
		int i;
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			rx = bits[i];
			repeat (`HB_CLKS_PER_BIT) @(negedge clk);
		end
	endtask

	// hand side of the bus
	initial begin : hand_model
		logic [7:0] frame [0:`HB_RESPONSE_LEN-1];
		logic [15:0] crc;
		logic [15:0] echo;
		int reply;
		int flip;
		int k;
		int j;
		seed = 32'hf29f_9904;
		rx = 1'b1;
		for (j = 0; j < `HB_JOINTS; j++)
			setpoint[j] = 16'($random(seed));
		@(negedge reset);
		forever begin
			for (k = 0; k < `HB_HEADER_LEN; k++)
				take_tx_byte(frame[k]);
			if ({frame[0], frame[1], frame[2], frame[3]} != `HB_REQUEST_HEADER) begin
				for (k = `HB_HEADER_LEN; k < `HB_COMMAND_LEN; k++)
					take_tx_byte(frame[k]);   // command, nothing to answer
			end else begin
				for (k = `HB_HEADER_LEN; k < `HB_REQUEST_LEN; k++)
					take_tx_byte(frame[k]);
				wait (!tx_enable);
				repeat (2 + $unsigned($random(seed)) % 16) @(negedge clk);
				if ($random(seed) & 1) begin
					for (j = 0; j < `HB_JOINTS; j++)
						setpoint[j] = 16'($random(seed));
				end
				reply = $unsigned($random(seed)) % 4;   // 0 good, 1 bad crc, 2 wrong id, 3 silent
				flip = ($random(seed) & 1) ? $unsigned($random(seed)) % 4 : -1;
				if (reply != 3) begin
					{frame[0], frame[1], frame[2], frame[3]} = `HB_RESPONSE_HEADER;
					frame[4] = (reply == 2) ? hand_id ^ (8'($random(seed)) | 8'h01) : hand_id;
					frame[5] = 8'($random(seed));
					for (j = 0; j < `HB_JOINTS; j++) begin
						echo = setpoint[j];
						if (j == flip)
							echo = echo ^ (16'($random(seed)) | 16'h0001);
						{frame[6 + 2*j], frame[7 + 2*j]} = echo;
						{frame[14 + 2*j], frame[15 + 2*j]} = 16'($random(seed));
						{frame[22 + 2*j], frame[23 + 2*j]} = 16'($random(seed));
					end
					crc = `HB_CRC_INIT;
					for (k = `HB_HEADER_LEN; k < `HB_RESPONSE_LEN - 2; k++)
						crc = crc_next(crc, frame[k]);
					if (reply == 1)
						crc = crc ^ (16'($random(seed)) | 16'h0001);
					{frame[30], frame[31]} = crc;
					for (k = 0; k < `HB_RESPONSE_LEN; k++)
						send_rx_byte(frame[k]);
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		hand_id = 8'h3c;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		wait (request_count > ROUNDS);
		repeat (`HB_CLKS_PER_BIT) @(negedge clk);
		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not end within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/hand_bus_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/status_frame_receiver.sv
design/poll_sequencer.sv
design/frame_transmitter.sv
design/hand_bus_master.sv
bench/hand_bus_checker.sv
bench/tb_hand_bus.sv

//--- Makefile
SOURCES := $(filter-out +%,$(shell cat vlog.f)) design/hand_bus_config.svh

obj_dir/Vtb_hand_bus: vlog.f $(SOURCES)
	verilator --binary --timing --top-module tb_hand_bus -f vlog.f -o Vtb_hand_bus

run: obj_dir/Vtb_hand_bus
	@out="$$(./obj_dir/Vtb_hand_bus)"; echo "$$out"; echo "$$out" | grep -qx 'Verification passed'

clean:
	rm -rf obj_dir

.PHONY: run clean
